// ==== sim.f ====
rtl/usb_xact_pkg.sv
rtl/token_decoder.sv
rtl/toggle_bank.sv
rtl/in_responder.sv
rtl/out_router.sv
rtl/usb_xact_top.sv
dv/tb_usb_xact.sv

// ==== Makefile ====
# Verilator build and run of the USB transaction layer testbench
TOP := tb_usb_xact

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run, check sim.log"
	@echo "make clean  remove build output and log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) -f sim.f
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Simulation FAILED" sim.log; then echo "test failed"; exit 1; fi
	@grep -q "Simulation PASSED" sim.log || (echo "no pass line in sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log

// ==== dv/tb_usb_xact.sv ====
/*
 * directed testbench for usb_xact_top, the packet layer is modelled by tasks
 * one transmit byte is requested every second cycle
 * ep0 user answers resp_idx ^ 8'h5a, bulk and OUT payloads come from an LFSR
 */
`timescale 1ns/1ps
`default_nettype none

module tb_usb_xact;

    localparam int          EP_MAX      = 32;   // both packet sizes
    localparam int          NUM_TESTS   = 6;
    localparam int          TEST_CYCLES = 600;  // worst test is well below
    localparam int          WATCHDOG_NS = NUM_TESTS * TEST_CYCLES * 20;
    localparam logic [7:0]  RESP_KEY    = 8'h5a;
    localparam logic [31:0] SEED        = 32'h61c58c13;

    logic                     clk;
    logic                     rstn;
    usb_xact_pkg::rx_pkt_t    rx;
    usb_xact_pkg::tx_pkt_t    tx;
    logic                     tx_byte_req;
    logic                     sot, sof;
    usb_xact_pkg::setup_cmd_t setup_cmd;
    usb_xact_pkg::resp_idx_t  resp_idx;
    usb_xact_pkg::byte_t      ep0_resp;
    usb_xact_pkg::byte_t      in1_data, in2_data, out1_data, out2_data;
    logic                     in1_valid, in1_ready, in2_valid, in2_ready;
    logic                     out1_valid, out2_valid;

    int                  errors = 0;
    int                  sot_cnt = 0;   // pulse counters from the monitor
    int                  sof_cnt = 0;
    int                  sta_cnt = 0;
    int                  out1_cnt = 0;
    int                  out2_cnt = 0;
    int                  in1_rdy_cnt = 0;
    logic [31:0]         lfsr;
    usb_xact_pkg::pid_t  got_pid;
    usb_xact_pkg::byte_t got_q[$];      // bytes of the last collected packet
    usb_xact_pkg::byte_t exp_q[$];
    usb_xact_pkg::byte_t out1_q[$];
    usb_xact_pkg::byte_t out2_q[$];
    usb_xact_pkg::byte_t in2_sent[$];   // bytes taken from the ep2 source

    usb_xact_top #(.EP0_MAX_PKT(EP_MAX), .EPIN_MAX_PKT(EP_MAX)) uut (.*);

    assign ep0_resp = resp_idx[7:0] ^ RESP_KEY;  // user byte by index

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // pulse monitor, samples values from before the edge
    always @(posedge clk) begin
        if (sot)
            sot_cnt++;
        if (sof)
            sof_cnt++;
        if (tx.sta)
            sta_cnt++;
        if (in1_ready)
            in1_rdy_cnt++;
        if (out2_valid) begin
            out2_cnt++;
            out2_q.push_back(out2_data);
        end
        if (out1_valid) begin
            out1_cnt++;
            out1_q.push_back(out1_data);
        end
    end

    //--------------------------------------------------
    // helpers
    //--------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32+x^22+x^2+x+1
    endfunction

    task automatic rand_byte(output usb_xact_pkg::byte_t b);
        int i;
        for (i = 0; i < 8; i++) begin
            lfsr = lfsr_next(lfsr);
            b = {b[6:0], lfsr[0]};  // one step per bit
        end
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        errors++;
        $display("Fail %s got 0x%0h expected 0x%0h", name, got, exp);
    endtask

    task automatic next_cycle;
        @(posedge clk);
        #2;  // drive point
    endtask

    task automatic drive_rx(input usb_xact_pkg::pid_t pid, input usb_xact_pkg::endp_t endp,
                            input logic byte_en, input usb_xact_pkg::byte_t data,
                            input logic fin);
        rx.pid     = pid;
        rx.endp    = endp;
        rx.byte_en = byte_en;
        rx.data    = data;
        rx.fin     = fin;
        rx.okay    = fin;  // every packet is good
    endtask

    task automatic send_token(input usb_xact_pkg::pid_t pid, input usb_xact_pkg::endp_t endp);
        next_cycle();
        drive_rx(pid, endp, 1'b0, 8'h00, 1'b1);
        next_cycle();
        drive_rx(4'h0, 4'h0, 1'b0, 8'h00, 1'b0);
    endtask

    task automatic send_data(input usb_xact_pkg::pid_t pid, input usb_xact_pkg::byte_t bytes[$]);
        int i;
        for (i = 0; i < bytes.size(); i++) begin
            next_cycle();
            drive_rx(pid, 4'h0, 1'b1, bytes[i], 1'b0);
        end
        next_cycle();
        drive_rx(pid, 4'h0, 1'b0, 8'h00, 1'b1);  // end of packet, crc good
        next_cycle();
        drive_rx(4'h0, 4'h0, 1'b0, 8'h00, 1'b0);
    endtask

    // one byte request, answer read a cycle later
    task automatic request_byte(output logic fin_n, output usb_xact_pkg::byte_t d);
        logic take2;
        next_cycle();
        tx_byte_req = 1'b1;
        #1;
        take2 = in2_valid && in2_ready;  // byte leaves the source at next edge
        next_cycle();
        tx_byte_req = 1'b0;
        fin_n = tx.fin_n;
        d     = tx.data;
        if (take2) begin
            in2_sent.push_back(in2_data);
            rand_byte(in2_data);  // source presents its next byte
        end
    endtask

    task automatic collect_packet;
        logic                fin_n;
        usb_xact_pkg::byte_t d;
        int                  waited;
        got_q.delete();
        got_pid = 4'h0;
        waited  = 0;
        @(posedge clk);
        #1;
        while (!tx.sta && waited < 20) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!tx.sta) begin
            errors++;
            $display("no transmit packet started within 20 cycles");
        end else begin
            got_pid = tx.pid;
            fin_n   = 1'b1;
            while (fin_n && got_q.size() < 1100) begin
                request_byte(fin_n, d);
                if (fin_n)
                    got_q.push_back(d);
            end
        end
    endtask

    task automatic compare_queues(input string name);
        int i;
        if (got_q.size() != exp_q.size())
            report_mismatch({name, " count"}, 64'(got_q.size()), 64'(exp_q.size()));
        for (i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
            if (got_q[i] !== exp_q[i])
                report_mismatch(name, 64'(got_q[i]), 64'(exp_q[i]));
        end
    endtask

    task automatic check_packet(input string name, input usb_xact_pkg::pid_t exp_pid);
        if (got_pid !== exp_pid)
            report_mismatch({"tx.pid ", name}, 64'(got_pid), 64'(exp_pid));
        compare_queues({"tx.data ", name});
    endtask

    //--------------------------------------------------
    // directed tests
    //--------------------------------------------------
    task automatic idle_after_reset;
        repeat (10) next_cycle();
        if (sta_cnt != 0)
            report_mismatch("tx.sta pulses", 64'(sta_cnt), 64'(0));
        if (sot_cnt != 0 || sof_cnt != 0)
            report_mismatch("sot sof pulses", 64'(sot_cnt + sof_cnt), 64'(0));
        if (out1_cnt != 0 || out2_cnt != 0)
            report_mismatch("out valid pulses", 64'(out1_cnt + out2_cnt), 64'(0));
        if (setup_cmd !== '0)
            report_mismatch("setup_cmd", setup_cmd, 64'(0));
    endtask

    task automatic start_pulses;
        int sot0;
        int sof0;
        sot0 = sot_cnt;
        sof0 = sof_cnt;
        send_token(usb_xact_pkg::PID_SOF, 4'd0);
        repeat (3) next_cycle();
        if (sof_cnt != sof0 + 1)
            report_mismatch("sof pulses", 64'(sof_cnt - sof0), 64'(1));
        send_token(usb_xact_pkg::PID_IN, 4'd1);  // ep1 source idle
        collect_packet();
        exp_q.delete();
        check_packet("ep1 idle IN", usb_xact_pkg::PID_NAK);
        if (in1_rdy_cnt != 0)  // NAK leaves no count, ep1 never ready
            report_mismatch("in1_ready pulses", 64'(in1_rdy_cnt), 64'(0));
        send_token(usb_xact_pkg::PID_SETUP, 4'd0);
        repeat (3) next_cycle();
        send_token(usb_xact_pkg::PID_OUT, 4'd0);  // no pulse for ep0 OUT
        repeat (3) next_cycle();
        if (sot_cnt != sot0 + 2)
            report_mismatch("sot pulses", 64'(sot_cnt - sot0), 64'(2));
        if (sof_cnt != sof0 + 1)
            report_mismatch("sof pulses after tokens", 64'(sof_cnt - sof0), 64'(1));
    endtask

    task automatic setup_capture;
        usb_xact_pkg::byte_t cmd[$];
        usb_xact_pkg::byte_t b;
        logic [63:0]         exp;
        int                  i;
        for (i = 0; i < 8; i++) begin
            rand_byte(b);
            cmd.push_back(b);
            exp[8*i +: 8] = b;  // first byte ends lowest
        end
        send_token(usb_xact_pkg::PID_SETUP, 4'd0);
        send_data(usb_xact_pkg::PID_DATA0, cmd);
        collect_packet();
        exp_q.delete();
        check_packet("setup ACK", usb_xact_pkg::PID_ACK);
        if (setup_cmd !== exp)
            report_mismatch("setup_cmd", setup_cmd, exp);
    endtask

    task automatic ep0_control_in;
        logic [63:0]         req;
        usb_xact_pkg::byte_t cmd[$];
        int                  i;
        req = 64'h0028_0000_0100_0680;  // GET_DESCRIPTOR, device to host, wLength 40
        for (i = 0; i < 8; i++)
            cmd.push_back(req[8*i +: 8]);
        send_token(usb_xact_pkg::PID_SETUP, 4'd0);
        send_data(usb_xact_pkg::PID_DATA0, cmd);
        collect_packet();
        exp_q.delete();
        check_packet("ep0 setup ACK", usb_xact_pkg::PID_ACK);
        send_token(usb_xact_pkg::PID_IN, 4'd0);
        collect_packet();
        for (i = 0; i < 32; i++)
            exp_q.push_back(8'(i) ^ RESP_KEY);
        check_packet("ep0 IN 1", usb_xact_pkg::PID_DATA1);
        send_token(usb_xact_pkg::PID_IN, 4'd0);
        collect_packet();
        exp_q.delete();
        for (i = 32; i < 40; i++)
            exp_q.push_back(8'(i) ^ RESP_KEY);
        check_packet("ep0 IN 2", usb_xact_pkg::PID_DATA0);
        send_token(usb_xact_pkg::PID_IN, 4'd0);  // transfer already done
        collect_packet();
        exp_q.delete();
        check_packet("ep0 IN 3", usb_xact_pkg::PID_DATA1);
    endtask

    task automatic bulk_in_ep2;
        send_token(usb_xact_pkg::PID_IN, 4'd2);
        collect_packet();
        exp_q.delete();
        check_packet("ep2 empty IN", usb_xact_pkg::PID_NAK);
        rand_byte(in2_data);
        in2_valid = 1'b1;
        in2_sent.delete();
        send_token(usb_xact_pkg::PID_IN, 4'd2);
        collect_packet();
        exp_q = in2_sent;
        if (in2_sent.size() != EP_MAX)
            report_mismatch("in2_ready takes", 64'(in2_sent.size()), 64'(EP_MAX));
        check_packet("ep2 IN 1", usb_xact_pkg::PID_DATA0);
        in2_sent.delete();
        send_token(usb_xact_pkg::PID_IN, 4'd2);
        collect_packet();
        exp_q = in2_sent;
        if (in2_sent.size() != EP_MAX)
            report_mismatch("in2_ready takes", 64'(in2_sent.size()), 64'(EP_MAX));
        check_packet("ep2 IN 2", usb_xact_pkg::PID_DATA1);
        in2_valid = 1'b0;
    endtask

    task automatic out_endpoints;
        usb_xact_pkg::byte_t pay[$];
        usb_xact_pkg::byte_t b;
        int                  i;
        int                  out2_0;
        for (i = 0; i < 12; i++) begin
            rand_byte(b);
            pay.push_back(b);
        end
        out1_q.delete();
        out2_0 = out2_cnt;
        send_token(usb_xact_pkg::PID_OUT, 4'd1);
        send_data(usb_xact_pkg::PID_DATA0, pay);
        collect_packet();
        exp_q.delete();
        check_packet("ep1 OUT ACK", usb_xact_pkg::PID_ACK);
        got_q = out1_q;
        exp_q = pay;
        compare_queues("out1_data");
        if (out2_cnt != out2_0)
            report_mismatch("out2_valid pulses", 64'(out2_cnt - out2_0), 64'(0));
        // short packet on ep2, bytes must show on out2 only
        pay.delete();
        for (i = 0; i < 4; i++) begin
            rand_byte(b);
            pay.push_back(b);
        end
        out2_q.delete();
        send_token(usb_xact_pkg::PID_OUT, 4'd2);
        send_data(usb_xact_pkg::PID_DATA1, pay);
        collect_packet();
        exp_q.delete();
        check_packet("ep2 OUT ACK", usb_xact_pkg::PID_ACK);
        got_q = out2_q;
        exp_q = pay;
        compare_queues("out2_data");
    endtask

    //--------------------------------------------------
    // run control
    //--------------------------------------------------
    initial begin
        rstn        = 1'b0;
        rx          = '0;
        tx_byte_req = 1'b0;
        in1_data    = 8'h00;
        in1_valid   = 1'b0;  // ep1 source never has data
        in2_data    = 8'h00;
        in2_valid   = 1'b0;
        lfsr        = SEED;
        repeat (3) @(posedge clk);
        #2;
        rstn = 1'b1;
        idle_after_reset();
        start_pulses();
        setup_capture();
        ep0_control_in();
        bulk_in_ep2();
        out_endpoints();
        $display("tests: %0d, errors: %0d", NUM_TESTS, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, tests did not complete", WATCHDOG_NS);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/usb_xact_top.sv ====
/*
 * full-speed USB device transaction layer, endpoints 0, 0x81/0x82, 0x01/0x02
 * no descriptor ROM, every ep0 IN byte comes from ep0_resp by resp_idx
 * no isochronous support, every data packet gets an ACK
 */
`timescale 1ns/1ps
`default_nettype none

module usb_xact_top #(
    parameter int EP0_MAX_PKT  = 32,  // ep0 packet size
    parameter int EPIN_MAX_PKT = 32   // bulk IN packet size
) (
    input  wire                             clk,
    input  wire                             rstn,
    // packet layer
    input  wire usb_xact_pkg::rx_pkt_t      rx,
    output usb_xact_pkg::tx_pkt_t           tx,
    input  wire                             tx_byte_req,
    // transfer and frame starts
    output logic                            sot,
    output logic                            sof,
    // control endpoint
    output usb_xact_pkg::setup_cmd_t        setup_cmd,
    output usb_xact_pkg::resp_idx_t         resp_idx,
    input  wire usb_xact_pkg::byte_t        ep0_resp,
    // bulk IN 0x81, 0x82
    input  wire usb_xact_pkg::byte_t        in1_data,
    input  wire                             in1_valid,
    output logic                            in1_ready,
    input  wire usb_xact_pkg::byte_t        in2_data,
    input  wire                             in2_valid,
    output logic                            in2_ready,
    // OUT 0x01, 0x02
    output usb_xact_pkg::byte_t             out1_data,
    output logic                            out1_valid,
    output usb_xact_pkg::byte_t             out2_data,
    output logic                            out2_valid
);

    usb_xact_pkg::tok_t  tok;
    usb_xact_pkg::endp_t cur_endp;
    logic                setup_phase;
    logic [2:0]          tog_flip;
    logic                tog_preset_ep0;
    logic [2:0]          tog_state;

    token_decoder u_dec (
        .clk(clk), .rstn(rstn), .rx(rx), .tok(tok), .cur_endp(cur_endp),
        .setup_phase(setup_phase), .sot(sot), .sof(sof)
    );

    toggle_bank u_tog (
        .clk(clk), .rstn(rstn), .tog_flip(tog_flip),
        .tog_preset_ep0(tog_preset_ep0), .tog_state(tog_state)
    );

    in_responder #(
        .EP0_MAX_PKT (EP0_MAX_PKT),
        .EPIN_MAX_PKT(EPIN_MAX_PKT)
    ) u_in (
        .clk(clk), .rstn(rstn), .tok(tok), .cur_endp(cur_endp),
        .setup_phase(setup_phase), .setup_cmd(setup_cmd), .tog_state(tog_state),
        .tx_byte_req(tx_byte_req), .ep0_resp(ep0_resp),
        .in1_data(in1_data), .in1_valid(in1_valid),
        .in2_data(in2_data), .in2_valid(in2_valid),
        .tx(tx), .resp_idx(resp_idx), .in1_ready(in1_ready), .in2_ready(in2_ready),
        .tog_flip(tog_flip), .tog_preset_ep0(tog_preset_ep0)
    );

    out_router u_out (
        .clk(clk), .rstn(rstn), .rx(rx), .cur_endp(cur_endp),
        .setup_phase(setup_phase), .setup_cmd(setup_cmd),
        .out1_data(out1_data), .out1_valid(out1_valid),
        .out2_data(out2_data), .out2_valid(out2_valid)
    );

endmodule

`default_nettype wire

// ==== rtl/out_router.sv ====
/*
 * routes received payload bytes by the current endpoint
 * ep0 bytes in the setup phase build setup_cmd, first byte ends lowest
 * ep1/ep2 outputs have no back-pressure, the user must take every byte
 */
`timescale 1ns/1ps
`default_nettype none

module out_router (
    input  wire                             clk,
    input  wire                             rstn,
    input  wire usb_xact_pkg::rx_pkt_t      rx,
    input  wire usb_xact_pkg::endp_t        cur_endp,
    input  wire                             setup_phase,
    output usb_xact_pkg::setup_cmd_t        setup_cmd,
    output usb_xact_pkg::byte_t             out1_data,
    output logic                            out1_valid,
    output usb_xact_pkg::byte_t             out2_data,
    output logic                            out2_valid
);

    //--------------------------------------------------
    // control state, setup shift and byte strobes
    //--------------------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            setup_cmd  <= '0;
            out1_valid <= 1'b0;
            out2_valid <= 1'b0;
        end else begin
            out1_valid <= rx.byte_en && (cur_endp == 4'd1);  // one cycle per byte
            out2_valid <= rx.byte_en && (cur_endp == 4'd2);
            if (rx.byte_en && (cur_endp == 4'd0) && setup_phase)
                setup_cmd <= usb_xact_pkg::setup_cmd_t'({rx.data, setup_cmd[63:8]});  // shift down
        end
    end

    // payload holding registers
    always_ff @(posedge clk) begin
        if (rx.byte_en && (cur_endp == 4'd1))
            out1_data <= rx.data;
        if (rx.byte_en && (cur_endp == 4'd2))
            out2_data <= rx.data;
    end

endmodule

`default_nettype wire

// ==== rtl/in_responder.sv ====
/*
 * answers tokens and data packets toward the packet layer
 * ep0 bytes come from the user by resp_idx, bulk bytes by valid/ready
 * count is reloaded only by an IN token, a dropped valid ends a packet short
 */
`timescale 1ns/1ps
`default_nettype none

module in_responder #(
    parameter int EP0_MAX_PKT  = 32,
    parameter int EPIN_MAX_PKT = 32
) (
    input  wire                          clk,
    input  wire                          rstn,
    input  wire usb_xact_pkg::tok_t      tok,
    input  wire usb_xact_pkg::endp_t     cur_endp,
    input  wire                          setup_phase,
    input  wire usb_xact_pkg::setup_cmd_t setup_cmd,
    input  wire                    [2:0] tog_state,
    input  wire                          tx_byte_req,
    input  wire usb_xact_pkg::byte_t     ep0_resp,
    input  wire usb_xact_pkg::byte_t     in1_data,
    input  wire                          in1_valid,
    input  wire usb_xact_pkg::byte_t     in2_data,
    input  wire                          in2_valid,
    output usb_xact_pkg::tx_pkt_t        tx,
    output usb_xact_pkg::resp_idx_t      resp_idx,
    output logic                         in1_ready,
    output logic                         in2_ready,
    output logic                   [2:0] tog_flip,
    output logic                         tog_preset_ep0
);

    localparam usb_xact_pkg::pkt_len_t  EP0_LEN  = usb_xact_pkg::pkt_len_t'(EP0_MAX_PKT);
    localparam usb_xact_pkg::xfer_len_t EP0_XLEN = usb_xact_pkg::xfer_len_t'(EP0_MAX_PKT);
    localparam usb_xact_pkg::pkt_len_t  EPIN_LEN = usb_xact_pkg::pkt_len_t'(EPIN_MAX_PKT);

    usb_xact_pkg::pkt_len_t  cnt;      // bytes left in this packet
    usb_xact_pkg::xfer_len_t rem;      // bytes left in the ep0 transfer
    usb_xact_pkg::endp_t     tx_endp;  // source of the running packet
    logic                    is_in;
    logic                    bulk_ok;  // IN on ep1/ep2 with data pending
    logic                    src_valid;
    usb_xact_pkg::byte_t     src_data;

    assign is_in   = (tok.kind == usb_xact_pkg::tok_in);
    assign bulk_ok = ((tok.endp == 4'd1) && in1_valid) || ((tok.endp == 4'd2) && in2_valid);

    // toggle commands, applied by the bank at the same edge as tx.sta
    assign tog_preset_ep0 = (tok.kind == usb_xact_pkg::tok_setup);
    assign tog_flip[0]    = is_in && (tok.endp == 4'd0);
    assign tog_flip[1]    = is_in && (tok.endp == 4'd1) && in1_valid;
    assign tog_flip[2]    = is_in && (tok.endp == 4'd2) && in2_valid;

    //--------------------------------------------------
    // byte source mux
    //--------------------------------------------------
    always_comb begin
        case (tx_endp)
            4'd0:    begin src_valid = 1'b1;      src_data = ep0_resp; end  // user answers by idx
            4'd1:    begin src_valid = in1_valid; src_data = in1_data; end
            4'd2:    begin src_valid = in2_valid; src_data = in2_data; end
            default: begin src_valid = 1'b0;      src_data = '0;       end
        endcase
    end

    assign in1_ready = tx_byte_req && (cnt != '0) && (tx_endp == 4'd1);
    assign in2_ready = tx_byte_req && (cnt != '0) && (tx_endp == 4'd2);

    //--------------------------------------------------
    // responses and byte streaming
    //--------------------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            tx       <= '0;
            cnt      <= '0;
            rem      <= '0;
            tx_endp  <= '0;
            resp_idx <= '0;
        end else begin
            tx.sta <= 1'b0;
            if (tx_byte_req) begin
                tx.fin_n <= 1'b0;  // nothing left, end of packet
                if ((cnt != '0) && src_valid) begin
                    cnt      <= cnt - 10'd1;
                    tx.fin_n <= 1'b1;
                    tx.data  <= src_data;
                    if (tx_endp == 4'd0)
                        resp_idx <= resp_idx + 9'd1;
                end
            end
            if (is_in) begin
                tx.sta  <= 1'b1;
                tx.pid  <= usb_xact_pkg::PID_NAK;  // default, no bytes
                cnt     <= '0;
                tx_endp <= tok.endp;
                if (tok.endp == 4'd0) begin
                    tx.pid <= tog_state[0] ? usb_xact_pkg::PID_DATA1 : usb_xact_pkg::PID_DATA0;
                    if (rem >= EP0_XLEN) begin  // full packet, more may follow
                        cnt <= EP0_LEN;
                        rem <= rem - EP0_XLEN;
                    end else begin              // last, possibly empty
                        cnt <= rem[9:0];
                        rem <= '0;
                    end
                end else if (bulk_ok) begin
                    tx.pid <= tog_state[tok.endp[1:0]] ? usb_xact_pkg::PID_DATA1
                                                       : usb_xact_pkg::PID_DATA0;
                    cnt    <= EPIN_LEN;
                end
            end else if (tok.kind == usb_xact_pkg::tok_data) begin
                tx.sta <= 1'b1;
                tx.pid <= usb_xact_pkg::PID_ACK;  // every data packet is acked
                if ((cur_endp == 4'd0) && setup_phase) begin  // SETUP stage done
                    rem      <= setup_cmd.bm_request_type[7] ? setup_cmd.wlength : '0;
                    resp_idx <= '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/toggle_bank.sv ====
/*
 * DATA0/DATA1 state, one bit per IN endpoint 0..2, 1 means DATA1
 * preset and flip never hit endpoint 0 in the same cycle
 */
`timescale 1ns/1ps
`default_nettype none

module toggle_bank (
    input  wire        clk,
    input  wire        rstn,
    input  wire  [2:0] tog_flip,        // one-hot per endpoint
    input  wire        tog_preset_ep0,  // SETUP forces ep0 to DATA1
    output logic [2:0] tog_state
);

    logic [2:0] tog_next;

    // flips first, preset wins on ep0
    always_comb begin
        tog_next = tog_state ^ tog_flip;
        if (tog_preset_ep0)
            tog_next[0] = 1'b1;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            tog_state <= '0;  // all endpoints start on DATA0
        else
            tog_state <= tog_next;
    end

endmodule

`default_nettype wire

// ==== rtl/token_decoder.sv ====
/*
 * decodes packets accepted on fin & okay into one-cycle token events
 * only SETUP, OUT and IN carry an endpoint; data packets reuse cur_endp
 * everything is registered, one cycle after the accepting edge
 */
`timescale 1ns/1ps
`default_nettype none

module token_decoder (
    input  wire                     clk,
    input  wire                     rstn,
    input  wire usb_xact_pkg::rx_pkt_t rx,
    output usb_xact_pkg::tok_t      tok,
    output usb_xact_pkg::endp_t     cur_endp,
    output logic                    setup_phase,
    output logic                    sot,
    output logic                    sof
);

    logic accept;  // whole good packet this cycle
    logic is_tok;  // SETUP, OUT or IN token

    assign accept = rx.fin & rx.okay;
    assign is_tok = (rx.pid == usb_xact_pkg::PID_SETUP) ||
                    (rx.pid == usb_xact_pkg::PID_OUT) ||
                    (rx.pid == usb_xact_pkg::PID_IN);

    //--------------------------------------------------
    // token event and current endpoint
    //--------------------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            tok.kind    <= usb_xact_pkg::tok_none;
            tok.endp    <= '0;
            cur_endp    <= '0;
            setup_phase <= 1'b0;
        end else begin
            tok.kind <= usb_xact_pkg::tok_none;  // event lasts one cycle
            if (accept) begin
                tok.endp <= is_tok ? rx.endp : cur_endp;  // data keeps last token endp
                if (is_tok)
                    cur_endp <= rx.endp;
                case (rx.pid)
                    usb_xact_pkg::PID_SETUP: begin
                        tok.kind    <= usb_xact_pkg::tok_setup;
                        setup_phase <= 1'b1;
                    end
                    usb_xact_pkg::PID_OUT: begin
                        tok.kind    <= usb_xact_pkg::tok_out;
                        setup_phase <= 1'b0;
                    end
                    usb_xact_pkg::PID_IN: begin
                        tok.kind    <= usb_xact_pkg::tok_in;
                        setup_phase <= 1'b0;
                    end
                    usb_xact_pkg::PID_DATA0,
                    usb_xact_pkg::PID_DATA1: tok.kind <= usb_xact_pkg::tok_data;
                    default: ;  // SOF and handshakes are no token event
                endcase
            end
        end
    end

    //--------------------------------------------------
    // transfer and frame start pulses
    //--------------------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            sot <= 1'b0;
            sof <= 1'b0;
        end else begin
            sot <= 1'b0;
            sof <= 1'b0;
            if (accept) begin
                if (rx.endp == '0)
                    sot <= (rx.pid == usb_xact_pkg::PID_SETUP);  // control transfer
                else
                    sot <= (rx.pid == usb_xact_pkg::PID_IN) ||
                           (rx.pid == usb_xact_pkg::PID_OUT);    // bulk transfer
                sof <= (rx.pid == usb_xact_pkg::PID_SOF);
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/usb_xact_pkg.sv ====
/*
 * shared types for the full-speed USB transaction layer
 * PID codes follow USB 1.1, only the ones this device sends or decodes
 * setup_cmd_t matches the 8-byte SETUP stage, first byte in the low bits
 */
`default_nettype none

package usb_xact_pkg;

    //--------------------------------------------------
    // plain vectors with a meaning
    //--------------------------------------------------
    typedef logic [3:0]  pid_t;       // packet identifier, low nibble of PID byte
    typedef logic [3:0]  endp_t;      // endpoint number
    typedef logic [7:0]  byte_t;
    typedef logic [9:0]  pkt_len_t;   // bytes left in one packet
    typedef logic [8:0]  resp_idx_t;  // ep0 response byte index
    typedef logic [15:0] xfer_len_t;  // bytes left in the ep0 transfer

    // token and data PIDs
    localparam pid_t PID_OUT   = 4'h1;
    localparam pid_t PID_IN    = 4'h9;
    localparam pid_t PID_SETUP = 4'hD;
    localparam pid_t PID_SOF   = 4'h5;
    localparam pid_t PID_DATA0 = 4'h3;
    localparam pid_t PID_DATA1 = 4'hB;
    // handshakes, the only ones the device sends
    localparam pid_t PID_ACK   = 4'h2;
    localparam pid_t PID_NAK   = 4'hA;

    //--------------------------------------------------
    // decoded packet events
    //--------------------------------------------------
    typedef enum logic [2:0] {
        tok_none,   // idle cycle
        tok_setup,
        tok_out,
        tok_in,
        tok_data    // DATA0 or DATA1 received
    } tok_kind_t;

    typedef struct packed {
        tok_kind_t kind;
        endp_t     endp;  // token endpoint, or current endpoint for data
    } tok_t;

    //--------------------------------------------------
    // packet layer bundles
    //--------------------------------------------------
    typedef struct packed {
        pid_t  pid;
        endp_t endp;     // valid with token PIDs only
        logic  byte_en;  // one payload byte on data
        byte_t data;
        logic  fin;      // end of packet
        logic  okay;     // crc and pid check passed, with fin
    } rx_pkt_t;

    typedef struct packed {
        logic  sta;      // one-cycle start of a transmit packet
        pid_t  pid;
        byte_t data;     // answers the previous byte request
        logic  fin_n;    // low ends the packet
    } tx_pkt_t;

    // SETUP command, 64 bits
    typedef struct packed {
        xfer_len_t   wlength;
        logic [15:0] windex;
        logic [15:0] wvalue;
        byte_t       brequest;
        byte_t       bm_request_type;  // bit 7 set means device to host
    } setup_cmd_t;

endpackage

`default_nettype wire
